// ==== project.f ====
design/rob_pkg.sv
design/retire_if.sv
design/reorder_buffer.sv
design/rename_map.sv
design/arch_regfile.sv
design/commit_core.sv
tb/commit_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the commit slice testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module commit_core_tb \
    -o commit_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/commit_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0

// ==== tb/commit_core_tb.sv ====
//////////////////////////////////////////////////////////////////////
// random testbench for commit_core with ROB_DEPTH 8, checked by a
// queue model through concurrent assertions on the top ports
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module commit_core_tb import rob_pkg::*; ();

    localparam int DEPTH       = 8;
    localparam int TEST_CYCLES = 12 + 30 + 200 + 30;

    typedef struct {
        rob_tag_t  tag;
        arch_reg_t dest;
        opcode_t   op;
        word_t     value;
        logic      ready;
    } entry_t;

    logic clock, reset, load_entry, cdb_valid, retire_entry, rob_clear;
    arch_reg_t dispatch_dest, src_reg1, src_reg2, reg_dest;
    opcode_t   dispatch_opcode;
    rob_tag_t  cdb_tag, next_tag, src_tag1, src_tag2;
    word_t     cdb_value, reg_value, mem_addr, src_value1, src_value2;
    logic      dispatch_ack, rob_full, reg_valid, mem_valid, src_busy1, src_busy2;

    // reference model
    entry_t    model_q[$];
    rob_tag_t  pend [32];
    word_t     regs [32];
    int        tail_idx = 0;
    logic [31:0] lcg_state = 32'd43850;
    int        errors = 0;

    // expected port values
    rob_tag_t  exp_next_tag = 6'd1, exp_tag1, exp_tag2;
    logic      exp_full = 1'b0, exp_ack = 1'b0, exp_reg_valid = 1'b0, exp_mem_valid = 1'b0;
    logic      exp_busy1, exp_busy2;
    arch_reg_t exp_reg_dest;
    word_t     exp_reg_value, exp_mem_addr, exp_value1, exp_value2;

    commit_core #(.ROB_DEPTH(DEPTH)) UUT (.*);

    always #5 clock = ~clock;

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    function automatic logic chance(int percent);
        return (next_rand() % 100) < percent;
    endfunction

    function automatic logic reg_writer(opcode_t op);
        case (op)
            OPC_LOAD, OPC_OP_IMM, OPC_OP, OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic opcode_t pick_opcode(int idx);
        case (idx)
            0: return OPC_LOAD;
            1: return OPC_STORE;
            2: return OPC_OP_IMM;
            3: return OPC_OP;
            4: return OPC_JAL;
            5: return OPC_JALR;
            6: return OPC_LUI;
            7: return OPC_AUIPC;
            default: return OPC_BRANCH;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, want);
    endtask

    // pending and not ready -> busy, ready -> forwarded, else committed
    task automatic lookup(input arch_reg_t r, output logic busy, output rob_tag_t tag,
                          output word_t value);
        busy  = 1'b0;
        tag   = '0;
        value = (r == '0) ? '0 : regs[r];
        if (r != '0 && pend[r] != '0) begin
            foreach (model_q[i]) begin
                if (model_q[i].tag == pend[r]) begin
                    busy  = !model_q[i].ready;
                    tag   = busy ? pend[r] : '0;
                    value = busy ? '0 : model_q[i].value;
                end
            end
        end
    endtask

    task automatic compute_expect();
        exp_next_tag = rob_tag_t'(tail_idx + 1);
        exp_full     = model_q.size() == DEPTH;
        lookup(src_reg1, exp_busy1, exp_tag1, exp_value1);
        lookup(src_reg2, exp_busy2, exp_tag2, exp_value2);
    endtask

    ////////////////////////////////////////////////////////////////////
    // model update for one clock edge
    ////////////////////////////////////////////////////////////////////
    task automatic apply_edge();
        logic   retire_ok, flush_now, accept;
        entry_t head;
        retire_ok = retire_entry && model_q.size() > 0 && model_q[0].ready;
        flush_now = retire_ok && rob_clear;
        accept    = load_entry && model_q.size() < DEPTH && !flush_now;
        if (retire_ok) head = model_q[0];
        exp_ack       = accept;
        exp_reg_valid = retire_ok && !rob_clear && reg_writer(head.op);
        exp_mem_valid = retire_ok && !rob_clear && head.op == OPC_STORE;
        if (retire_ok) begin
            exp_reg_dest  = head.dest;
            exp_reg_value = head.value;
            exp_mem_addr  = head.value;   // store value is its address
        end
        if (cdb_valid) begin
            foreach (model_q[i]) begin
                if (model_q[i].tag == cdb_tag) begin
                    model_q[i].ready = 1'b1;
                    model_q[i].value = cdb_value;
                end
            end
        end
        if (flush_now) begin
            model_q.delete();
            foreach (pend[i]) pend[i] = '0;
        end else begin
            if (retire_ok) begin
                void'(model_q.pop_front());
                if (reg_writer(head.op) && head.dest != '0) regs[head.dest] = head.value;
                if (pend[head.dest] == head.tag) pend[head.dest] = '0;
            end
            if (accept) begin
                model_q.push_back('{rob_tag_t'(tail_idx + 1), dispatch_dest,
                                    dispatch_opcode, '0, 1'b0});
                if (dispatch_dest != '0) pend[dispatch_dest] = rob_tag_t'(tail_idx + 1);
                tail_idx = (tail_idx + 1) % DEPTH;   // wraps DEPTH back to tag 1
            end
        end
    endtask

    // one random cycle per iteration, inputs change on the falling edge
    task automatic run_random(input int cycles, input int p_load, input int p_cdb,
                              input int p_retire, input int p_clear);
        int busy_tags[$];
        for (int n = 0; n < cycles; n++) begin
            @(negedge clock);
            busy_tags.delete();
            foreach (model_q[i]) if (!model_q[i].ready) busy_tags.push_back(int'(model_q[i].tag));
            retire_entry    = chance(p_retire);
            rob_clear       = retire_entry && chance(p_clear);
            load_entry      = chance(p_load) && !rob_clear;
            dispatch_opcode = pick_opcode(next_rand() % 9);
            dispatch_dest   = reg_writer(dispatch_opcode) ? arch_reg_t'(next_rand() % 8) : '0;
            cdb_valid       = busy_tags.size() > 0 && chance(p_cdb);
            cdb_tag         = cdb_valid ? rob_tag_t'(busy_tags[next_rand() % busy_tags.size()])
                                        : '0;
            cdb_value       = {16'(next_rand()), 16'(next_rand())};
            src_reg1        = arch_reg_t'(next_rand() % 8);
            src_reg2        = arch_reg_t'(next_rand() % 8);
            compute_expect();
            @(posedge clock);
            apply_edge();
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // port checks against the model
    ////////////////////////////////////////////////////////////////////
    a_next_tag: assert property (@(posedge clock) disable iff (reset) next_tag == exp_next_tag)
        else report_mismatch("next_tag", 32'($sampled(next_tag)), 32'($sampled(exp_next_tag)));
    a_full: assert property (@(posedge clock) disable iff (reset) rob_full == exp_full)
        else report_mismatch("rob_full", 32'($sampled(rob_full)), 32'($sampled(exp_full)));
    a_ack: assert property (@(posedge clock) disable iff (reset) dispatch_ack == exp_ack)
        else report_mismatch("dispatch_ack", 32'($sampled(dispatch_ack)), 32'($sampled(exp_ack)));
    a_reg_valid: assert property (@(posedge clock) disable iff (reset) reg_valid == exp_reg_valid)
        else report_mismatch("reg_valid", 32'($sampled(reg_valid)), 32'($sampled(exp_reg_valid)));
    a_mem_valid: assert property (@(posedge clock) disable iff (reset) mem_valid == exp_mem_valid)
        else report_mismatch("mem_valid", 32'($sampled(mem_valid)), 32'($sampled(exp_mem_valid)));
    a_reg_dest: assert property (@(posedge clock) disable iff (reset)
        exp_reg_valid |-> reg_dest == exp_reg_dest)
        else report_mismatch("reg_dest", 32'($sampled(reg_dest)), 32'($sampled(exp_reg_dest)));
    a_reg_value: assert property (@(posedge clock) disable iff (reset)
        exp_reg_valid |-> reg_value == exp_reg_value)
        else report_mismatch("reg_value", $sampled(reg_value), $sampled(exp_reg_value));
    a_mem_addr: assert property (@(posedge clock) disable iff (reset)
        exp_mem_valid |-> mem_addr == exp_mem_addr)
        else report_mismatch("mem_addr", $sampled(mem_addr), $sampled(exp_mem_addr));
    a_busy1: assert property (@(posedge clock) disable iff (reset) src_busy1 == exp_busy1)
        else report_mismatch("src_busy1", 32'($sampled(src_busy1)), 32'($sampled(exp_busy1)));
    a_busy2: assert property (@(posedge clock) disable iff (reset) src_busy2 == exp_busy2)
        else report_mismatch("src_busy2", 32'($sampled(src_busy2)), 32'($sampled(exp_busy2)));
    a_tag1: assert property (@(posedge clock) disable iff (reset) src_tag1 == exp_tag1)
        else report_mismatch("src_tag1", 32'($sampled(src_tag1)), 32'($sampled(exp_tag1)));
    a_tag2: assert property (@(posedge clock) disable iff (reset) src_tag2 == exp_tag2)
        else report_mismatch("src_tag2", 32'($sampled(src_tag2)), 32'($sampled(exp_tag2)));
    a_value1: assert property (@(posedge clock) disable iff (reset) src_value1 == exp_value1)
        else report_mismatch("src_value1", $sampled(src_value1), $sampled(exp_value1));
    a_value2: assert property (@(posedge clock) disable iff (reset) src_value2 == exp_value2)
        else report_mismatch("src_value2", $sampled(src_value2), $sampled(exp_value2));

    // watchdog sized from the cycle budget of all phases
    initial begin
        #((TEST_CYCLES + 10) * 10 + 500);
        $display("watchdog expired before the test sequence finished");
        $display("Test failures found");
        $finish;
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        {load_entry, cdb_valid, retire_entry, rob_clear} = '0;
        {dispatch_dest, src_reg1, src_reg2, cdb_tag} = '0;
        dispatch_opcode = OPC_OP;
        cdb_value = '0;
        foreach (pend[i]) pend[i] = '0;
        foreach (regs[i]) regs[i] = '0;
        compute_expect();
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        run_random(12, 100, 0, 0, 0);    // fill past full, tags 1..8
        run_random(30, 0, 40, 60, 0);    // out of order completion, in order retire
        run_random(200, 60, 50, 50, 4);  // mixed traffic with flushes and wrap
        run_random(30, 0, 100, 100, 0);  // drain
        @(negedge clock);
        $display("error count: %0d mismatches", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/commit_core.sv ====
//////////////////////////////////////////////////////////////////////
// commit slice top, ROB plus rename map plus register file
// handshakes are plain strobes, the dispatcher holds while rob_full
// stores and branches dispatch with destination x0
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module commit_core import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire logic      load_entry,
    input  wire arch_reg_t dispatch_dest,
    input  wire opcode_t   dispatch_opcode,
    input  wire logic      cdb_valid,
    input  wire rob_tag_t  cdb_tag,
    input  wire word_t     cdb_value,
    input  wire logic      retire_entry,
    input  wire logic      rob_clear,
    input  wire arch_reg_t src_reg1,
    input  wire arch_reg_t src_reg2,
    output rob_tag_t       next_tag,
    output logic           dispatch_ack,
    output logic           rob_full,
    output logic           reg_valid,
    output arch_reg_t      reg_dest,
    output word_t          reg_value,
    output logic           mem_valid,
    output word_t          mem_addr,
    output logic           src_busy1,
    output logic           src_busy2,
    output rob_tag_t       src_tag1,
    output rob_tag_t       src_tag2,
    output word_t          src_value1,
    output word_t          src_value2
);

    retire_if ret ();

    logic     dispatch_fire;
    rob_tag_t rob_read_tag1, rob_read_tag2;
    logic     rob_ready1, rob_ready2;
    word_t    rob_value1, rob_value2;
    word_t    rf_value1, rf_value2;

    assign dispatch_fire = load_entry && !rob_full;

    // retire outputs straight from the registered ROB strobes
    assign reg_valid = ret.reg_valid;
    assign reg_dest  = ret.reg_dest;
    assign reg_value = ret.reg_value;
    assign mem_valid = ret.mem_valid;
    assign mem_addr  = ret.mem_addr;

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clock, .reset, .load_entry, .dispatch_dest, .dispatch_opcode,
        .next_tag, .dispatch_ack, .rob_full,
        .cdb_valid, .cdb_tag, .cdb_value, .retire_entry, .rob_clear,
        .read_tag1(rob_read_tag1), .read_tag2(rob_read_tag2),
        .read_ready1(rob_ready1), .read_ready2(rob_ready2),
        .read_value1(rob_value1), .read_value2(rob_value2),
        .ret(ret.rob)
    );

    rename_map u_map (
        .clock, .reset, .dispatch_fire, .dispatch_dest,
        .dispatch_tag(next_tag), .src_reg1, .src_reg2,
        .rob_ready1, .rob_ready2, .rob_value1, .rob_value2,
        .rf_value1, .rf_value2, .rob_read_tag1, .rob_read_tag2,
        .src_busy1, .src_busy2, .src_tag1, .src_tag2, .src_value1, .src_value2,
        .ret(ret.map)
    );

    arch_regfile u_rf (
        .clock, .reset, .read_reg1(src_reg1), .read_reg2(src_reg2),
        .read_value1(rf_value1), .read_value2(rf_value2),
        .ret(ret.regfile)
    );

endmodule

`default_nettype wire

// ==== design/arch_regfile.sv ====
//////////////////////////////////////////////////////////////////////
// committed register file, written by retire, x0 reads as zero
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module arch_regfile import rob_pkg::*; (
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire arch_reg_t read_reg1,
    input  wire arch_reg_t read_reg2,
    output word_t          read_value1,
    output word_t          read_value2,
    retire_if.regfile      ret
);

    word_t regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ret.reg_valid && ret.reg_dest != '0) begin
            regs[ret.reg_dest] <= ret.reg_value;   // x0 writes dropped
        end
    end

    // combinational reads, no bypass of the same-edge write
    assign read_value1 = (read_reg1 == '0) ? '0 : regs[read_reg1];
    assign read_value2 = (read_reg2 == '0) ? '0 : regs[read_reg2];

endmodule

`default_nettype wire

// ==== design/rename_map.sv ====
//////////////////////////////////////////////////////////////////////
// rename map, one pending ROB tag per register, x0 never renamed
// lookups are combinational and mask all tags while a flush drains
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module rename_map import rob_pkg::*; (
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire logic      dispatch_fire,   // accepted dispatch
    input  wire arch_reg_t dispatch_dest,
    input  wire rob_tag_t  dispatch_tag,
    input  wire arch_reg_t src_reg1,
    input  wire arch_reg_t src_reg2,
    input  wire logic      rob_ready1,
    input  wire logic      rob_ready2,
    input  wire word_t     rob_value1,
    input  wire word_t     rob_value2,
    input  wire word_t     rf_value1,
    input  wire word_t     rf_value2,
    output rob_tag_t       rob_read_tag1,
    output rob_tag_t       rob_read_tag2,
    output logic           src_busy1,
    output logic           src_busy2,
    output rob_tag_t       src_tag1,
    output rob_tag_t       src_tag2,
    output word_t          src_value1,
    output word_t          src_value2,
    retire_if.map          ret
);

    rob_tag_t pend_tag [32];     // 0 = value lives in the register file
    rob_tag_t tag1, tag2;        // live tag per source

    always_ff @(posedge clock) begin
        if (reset || ret.flush) begin
            for (int i = 0; i < 32; i++) begin
                pend_tag[i] <= '0;
            end
        end else if (ret.reg_valid && pend_tag[ret.reg_dest] == ret.reg_tag) begin
            pend_tag[ret.reg_dest] <= '0;   // only if no younger writer took it
        end
        // a dispatch after the flush or to the retiring register wins
        if (!reset && dispatch_fire && dispatch_dest != '0)
            pend_tag[dispatch_dest] <= dispatch_tag;
    end

    assign tag1 = ret.flush ? '0 : pend_tag[src_reg1];
    assign tag2 = ret.flush ? '0 : pend_tag[src_reg2];
    assign rob_read_tag1 = tag1;
    assign rob_read_tag2 = tag2;

    // busy with tag / forwarded from ROB / committed value
    assign src_busy1  = (tag1 != '0) && !rob_ready1;
    assign src_busy2  = (tag2 != '0) && !rob_ready2;
    assign src_tag1   = src_busy1 ? tag1 : '0;
    assign src_tag2   = src_busy2 ? tag2 : '0;
    assign src_value1 = (tag1 == '0) ? rf_value1 : (rob_ready1 ? rob_value1 : '0);
    assign src_value2 = (tag2 == '0) ? rf_value2 : (rob_ready2 ? rob_value2 : '0);

    a_x0_free: assert property (@(posedge clock) disable iff (reset)
        pend_tag[0] == '0)
        else $error("x0 holds ROB tag %0d", pend_tag[0]);

endmodule

`default_nettype wire

// ==== design/reorder_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// circular re-order buffer, ROB_DEPTH a power of two from 4 to 32
// dispatch while full is dropped, as is a dispatch on a flush edge
// opcodes that write no register must dispatch with destination x0
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  wire logic clock,
    input  wire logic reset,
    // dispatch
    input  wire logic      load_entry,
    input  wire arch_reg_t dispatch_dest,
    input  wire opcode_t   dispatch_opcode,
    output rob_tag_t       next_tag,
    output logic           dispatch_ack,
    output logic           rob_full,
    // common data bus
    input  wire logic     cdb_valid,
    input  wire rob_tag_t cdb_tag,
    input  wire word_t    cdb_value,
    // retire control
    input  wire logic retire_entry,
    input  wire logic rob_clear,
    // operand read ports for the rename map
    input  wire rob_tag_t read_tag1,
    input  wire rob_tag_t read_tag2,
    output logic          read_ready1,
    output logic          read_ready2,
    output word_t         read_value1,
    output word_t         read_value2,
    retire_if.rob         ret
);

    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int PTR_W = IDX_W + 1;    // extra wrap bit

    rob_state_t state [ROB_DEPTH];
    opcode_t    opcode [ROB_DEPTH];
    arch_reg_t  dest [ROB_DEPTH];
    word_t      value [ROB_DEPTH];

    logic [PTR_W-1:0] head, tail;
    logic [IDX_W-1:0] head_idx, tail_idx, cdb_idx, rd_idx1, rd_idx2;
    opcode_t          head_op;
    logic             do_retire;  // head ready and retire asked
    logic             flush_now;  // retire with clear
    logic             accept;     // dispatch taken this edge

    // tag to entry index, tag 0 wraps to the last entry and is ignored
    function automatic logic [IDX_W-1:0] tag_to_idx(rob_tag_t tag);
        rob_tag_t t;
        t = tag - 1'b1;
        return t[IDX_W-1:0];
    endfunction

    assign head_idx = head[IDX_W-1:0];
    assign tail_idx = tail[IDX_W-1:0];
    assign cdb_idx  = tag_to_idx(cdb_tag);
    assign rd_idx1  = tag_to_idx(read_tag1);
    assign rd_idx2  = tag_to_idx(read_tag2);
    assign head_op  = opcode[head_idx];

    assign rob_full  = (head_idx == tail_idx) && (head[IDX_W] != tail[IDX_W]);
    assign next_tag  = rob_tag_t'(tail_idx) + 1'b1;
    assign do_retire = retire_entry && (state[head_idx] == ROB_READY);
    assign flush_now = do_retire && rob_clear;
    assign accept    = load_entry && !rob_full && !flush_now;  // squashed with the rest

    // a retired entry keeps its value until the register file write
    // one edge later, so an entry that is not busy still forwards
    assign read_ready1 = (read_tag1 != '0) && (state[rd_idx1] != ROB_BUSY);
    assign read_ready2 = (read_tag2 != '0) && (state[rd_idx2] != ROB_BUSY);
    assign read_value1 = value[rd_idx1];
    assign read_value2 = value[rd_idx2];

    //////////////////////////////////////////////////////////////////////
    // control state, pointers and retire strobes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state[i] <= ROB_EMPTY;
            end
            head          <= '0;
            tail          <= '0;
            dispatch_ack  <= 1'b0;
            ret.reg_valid <= 1'b0;
            ret.mem_valid <= 1'b0;
            ret.flush     <= 1'b0;
        end else begin
            dispatch_ack <= accept;
            if (cdb_valid)
                state[cdb_idx] <= ROB_READY;   // result arrived
            if (flush_now) begin
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    state[i] <= ROB_EMPTY;
                end
                head <= tail;                  // discard everything in flight
            end else begin
                if (do_retire) begin
                    state[head_idx] <= ROB_EMPTY;
                    head            <= head + 1'b1;
                end
                if (accept) begin
                    state[tail_idx] <= ROB_BUSY;
                    tail            <= tail + 1'b1;
                end
            end
            ret.reg_valid <= do_retire && !rob_clear && writes_regfile(head_op);
            ret.mem_valid <= do_retire && !rob_clear && writes_memory(head_op);
            ret.flush     <= flush_now;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // payload, written only when qualified
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (accept) begin
            opcode[tail_idx] <= dispatch_opcode;
            dest[tail_idx]   <= dispatch_dest;
        end
        if (cdb_valid)
            value[cdb_idx] <= cdb_value;
        if (do_retire) begin
            ret.reg_dest  <= dest[head_idx];
            ret.reg_value <= value[head_idx];
            ret.reg_tag   <= rob_tag_t'(head_idx) + 1'b1;
            ret.mem_addr  <= value[head_idx];    // store carries its address only
        end
    end

    // the CDB may only complete an instruction that is waiting
    a_cdb_busy: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> (cdb_tag != '0) && (cdb_tag <= rob_tag_t'(ROB_DEPTH)) &&
                      (state[cdb_idx] == ROB_BUSY))
        else $error("cdb tag %0d does not name a busy entry", cdb_tag);

    a_no_ack_full: assert property (@(posedge clock) disable iff (reset)
        load_entry && rob_full |=> !dispatch_ack)
        else $error("dispatch acknowledged while the ROB was full");

    // the rename map only learns of a retire through reg_valid
    a_dest_x0: assert property (@(posedge clock) disable iff (reset)
        load_entry && !rob_full && !writes_regfile(dispatch_opcode) |->
            dispatch_dest == '0)
        else $error("opcode %b dispatched with a destination", dispatch_opcode);

endmodule

`default_nettype wire

// ==== design/retire_if.sv ====
//////////////////////////////////////////////////////////////////////
// one retired instruction, registered in the ROB, valid for one cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface retire_if import rob_pkg::*; ();
    logic      reg_valid;   // register-file write strobe
    arch_reg_t reg_dest;
    word_t     reg_value;
    rob_tag_t  reg_tag;     // tag of the retired entry, for the map
    logic      mem_valid;   // store strobe
    word_t     mem_addr;
    logic      flush;       // whole-buffer squash

    modport rob (output reg_valid, reg_dest, reg_value, reg_tag,
                 output mem_valid, mem_addr, flush);
    modport map (input reg_valid, reg_dest, reg_tag, flush);
    modport regfile (input reg_valid, reg_dest, reg_value);
endinterface

`default_nettype wire

// ==== design/rob_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types and opcode decode for the commit slice
// a ROB tag is the entry index plus one, zero means no tag, so the
// 6-bit tag covers ROB depths up to 32
//////////////////////////////////////////////////////////////////////
`default_nettype none

package rob_pkg;

    typedef logic [31:0] word_t;      // data word or address
    typedef logic [4:0]  arch_reg_t;  // architectural register index
    typedef logic [6:0]  opcode_t;    // RV32 major opcode
    typedef logic [5:0]  rob_tag_t;   // entry index + 1, 0 = none

    typedef enum logic [1:0] {
        ROB_EMPTY,  // slot free
        ROB_BUSY,   // dispatched, waiting on the CDB
        ROB_READY   // result present, may retire
    } rob_state_t;

    // RV32 major opcodes
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // opcodes that commit a result to rd
    function automatic logic writes_regfile(opcode_t op);
        return (op == OPC_LOAD) || (op == OPC_OP_IMM) || (op == OPC_OP) ||
               (op == OPC_JAL) || (op == OPC_JALR) || (op == OPC_LUI) ||
               (op == OPC_AUIPC);
    endfunction

    // stores only, the value field holds the address
    function automatic logic writes_memory(opcode_t op);
        return op == OPC_STORE;
    endfunction

endpackage

`default_nettype wire
